/* build.f */
common/dcache_pkg.sv
dcache/dcache_tagv.sv
dcache/dcache_data.sv
dcache/dcache_lru.sv
dcache/dcache_ctrl.sv
hdl/dcache_top.sv
dv/mem_model.sv
dv/dcache_sva.sv
dv/tb_dcache.sv

/* common/dcache_pkg.sv */
// dcache geometry, address and data types, request structs, controller states and field helpers
package dcache_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // geometry
    ////////////////////////////////////////////////////////////////////////////

    localparam int INDEX_W    = 4;
    localparam int OFFSET_W   = 2;
    localparam int WAYS       = 2;
    localparam int LINE_WORDS = 1 << OFFSET_W;
    localparam int SETS       = 1 << INDEX_W;
    // the two lowest address bits pick a byte inside a word
    localparam int TAG_W      = 32 - INDEX_W - OFFSET_W - 2;

    // size code of a word transfer on the memory bus
    localparam logic [1:0] MEM_SIZE_WORD = 2'd2;

    typedef logic [31:0]              addr_t;
    typedef logic [31:0]              word_t;
    typedef logic [32*LINE_WORDS-1:0] line_t;
    typedef logic [TAG_W-1:0]         tag_t;
    typedef logic [INDEX_W-1:0]       index_t;
    typedef logic [OFFSET_W-1:0]      offset_t;
    typedef logic [3:0]               wstrb_t;

    ////////////////////////////////////////////////////////////////////////////
    // request structs
    ////////////////////////////////////////////////////////////////////////////

    // pipeline to cache
    typedef struct packed {
        addr_t  addr;
        word_t  wdata;
        wstrb_t wstrb;
        logic   write;
        logic   inval;
    } cache_req_t;

    // cache to memory
    typedef struct packed {
        logic       req;
        logic       wr;
        addr_t      addr;
        word_t      wdata;
        wstrb_t     wstrb;
        logic [1:0] size;
    } mem_req_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MISS_REQ,
        MISS_WAIT,
        WR_REQ,
        WR_WAIT,
        INVAL
    } ctrl_state_t;

    // address field split
    function automatic tag_t addr_tag(addr_t addr);
        return addr[31 -: TAG_W];
    endfunction

    function automatic index_t addr_index(addr_t addr);
        return addr[2+OFFSET_W +: INDEX_W];
    endfunction

    function automatic offset_t addr_offset(addr_t addr);
        return addr[2 +: OFFSET_W];
    endfunction

endpackage

/* dcache/dcache_ctrl.sv */
// request buffer, main FSM, memory request generation and read data selection
`timescale 1ns/1ps

module dcache_ctrl
    import dcache_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    // pipeline side
    input  logic             req_valid,
    input  cache_req_t       req,
    output logic             req_ready,
    output logic             resp_valid,
    output word_t            resp_data,
    // lookup results
    input  logic [WAYS-1:0]  hit,
    input  line_t [WAYS-1:0] rd_lines,
    input  logic             victim_way,
    // memory side
    output mem_req_t         mem_req,
    input  logic             mem_addr_ok,
    input  logic             mem_data_ok,
    input  logic             mem_bvalid,
    input  line_t            mem_rline,
    // tag array
    output index_t           rd_index,
    output index_t           wr_index,
    output tag_t             wr_tag,
    output logic [WAYS-1:0]  tag_we,
    output logic             tag_inval,
    // data array
    output logic [WAYS-1:0]  word_we,
    output offset_t          wr_offset,
    output wstrb_t           wr_strb,
    output word_t            wr_word,
    output logic [WAYS-1:0]  fill_we,
    // lru
    output logic             lru_use,
    output logic             lru_use_way
);

    ctrl_state_t     state;
    ctrl_state_t     state_nxt;
    cache_req_t      req_q;
    logic            accept;
    logic            hit_any;
    logic            lookup;
    logic            lookup_rd_hit;
    logic            lookup_to_mem;
    logic            fill;
    logic [WAYS-1:0] victim_mask;
    line_t           sel_line;

    assign accept        = req_valid && req_ready;
    assign hit_any       = |hit;
    assign lookup        = (state == LOOKUP);
    assign lookup_rd_hit = lookup && !req_q.write && hit_any;
    // stores always go out, loads only on a miss
    assign lookup_to_mem = lookup && (req_q.write || !hit_any);
    assign fill          = (state == MISS_WAIT) && mem_data_ok;
    assign victim_mask   = {{(WAYS-1){1'b0}}, 1'b1} << victim_way;

    // a read hit answers while the next request comes in
    assign req_ready = (state == IDLE) || lookup_rd_hit;

    ////////////////////////////////////////////////////////////////////////////
    // request buffer and FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= req;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (accept) begin
                    state_nxt = req.inval ? INVAL : LOOKUP;
                end
            end
            LOOKUP: begin
                if (lookup_rd_hit) begin
                    if (accept) begin
                        state_nxt = req.inval ? INVAL : LOOKUP;
                    end else begin
                        state_nxt = IDLE;
                    end
                end else if (req_q.write) begin
                    state_nxt = mem_addr_ok ? WR_WAIT : WR_REQ;
                end else begin
                    state_nxt = mem_addr_ok ? MISS_WAIT : MISS_REQ;
                end
            end
            MISS_REQ:  if (mem_addr_ok) state_nxt = MISS_WAIT;
            MISS_WAIT: if (mem_data_ok) state_nxt = IDLE;
            WR_REQ:    if (mem_addr_ok) state_nxt = WR_WAIT;
            WR_WAIT:   if (mem_bvalid)  state_nxt = IDLE;
            INVAL:     state_nxt = IDLE;
            default:   state_nxt = IDLE;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // memory request
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        mem_req.req   = lookup_to_mem || (state == MISS_REQ) || (state == WR_REQ);
        mem_req.wr    = req_q.write;
        // line aligned for refills
        mem_req.addr  = req_q.write ? req_q.addr :
                        {req_q.addr[31:2+OFFSET_W], {(2+OFFSET_W){1'b0}}};
        mem_req.wdata = req_q.wdata;
        mem_req.wstrb = req_q.write ? req_q.wstrb : '0;
        mem_req.size  = MEM_SIZE_WORD;
    end

    // array ports, reread the buffered set unless a new request arrives
    assign rd_index  = accept ? addr_index(req.addr) : addr_index(req_q.addr);
    assign wr_index  = addr_index(req_q.addr);
    assign wr_tag    = addr_tag(req_q.addr);
    assign wr_offset = addr_offset(req_q.addr);
    assign wr_strb   = req_q.wstrb;
    assign wr_word   = req_q.wdata;
    assign tag_inval = (state == INVAL);
    assign tag_we    = fill ? victim_mask : '0;
    assign fill_we   = fill ? victim_mask : '0;
    assign word_we   = (lookup && req_q.write) ? hit : '0;

    // lru touched by every hit and every refill
    assign lru_use     = (lookup && hit_any) || fill;
    assign lru_use_way = fill ? victim_way : hit[1];

    // read word from the hitting way or straight from the refill line
    always_comb begin
        sel_line = rd_lines[0];
        for (int w = 0; w < WAYS; w++) begin
            if (hit[w]) begin
                sel_line = rd_lines[w];
            end
        end
        if (state == MISS_WAIT) begin
            sel_line = mem_rline;
        end
        resp_data = sel_line[wr_offset*32 +: 32];
    end

    assign resp_valid = lookup_rd_hit || fill;

endmodule

/* dcache/dcache_data.sv */
// line data arrays for both ways with synchronous read, strobed word write and line fill
`timescale 1ns/1ps

module dcache_data
    import dcache_pkg::*;
(
    input  logic                  clk,
    input  index_t                rd_index,
    input  index_t                wr_index,
    input  offset_t               wr_offset,
    input  wstrb_t                wr_strb,
    input  word_t                 wr_word,
    input  logic [WAYS-1:0]       word_we,
    input  logic [WAYS-1:0]       fill_we,
    input  line_t                 fill_line,
    output line_t [WAYS-1:0]      rd_lines
);

    line_t line_mem [WAYS][SETS];

    ////////////////////////////////////////////////////////////////////////////
    // write and read ports
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        for (int w = 0; w < WAYS; w++) begin
            if (fill_we[w]) begin
                // refill from memory replaces the whole line
                line_mem[w][wr_index] <= fill_line;
            end else if (word_we[w]) begin
                // store hit, merge only enabled bytes
                for (int b = 0; b < 4; b++) begin
                    if (wr_strb[b]) begin
                        line_mem[w][wr_index][wr_offset*32 + b*8 +: 8] <= wr_word[b*8 +: 8];
                    end
                end
            end
            // read returns the old contents on a same-cycle write
            rd_lines[w] <= line_mem[w][rd_index];
        end
    end

endmodule

/* dcache/dcache_lru.sv */
// per-set LRU bit for two ways, update on use, victim way selection
`timescale 1ns/1ps

module dcache_lru
    import dcache_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  index_t index,
    input  logic   use_en,
    input  logic   use_way,
    output logic   victim_way
);

    // bit names the least recently used way of the set
    logic [SETS-1:0] lru_bits;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lru_bits <= '0;
        end else if (use_en) begin
            lru_bits[index] <= ~use_way;
        end
    end

    // sets only lose lines as a whole, so a fill always moves the bit to
    // the still empty way and the bit doubles as the invalid-way pick
    assign victim_way = lru_bits[index];

endmodule

/* dcache/dcache_tagv.sv */
// tag and valid arrays for both ways, synchronous read, per-way hit compare, set invalidate
`timescale 1ns/1ps

module dcache_tagv
    import dcache_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  index_t          rd_index,
    input  tag_t            cmp_tag,
    input  index_t          wr_index,
    input  tag_t            wr_tag,
    input  logic [WAYS-1:0] tag_we,
    input  logic            tag_inval,
    output logic [WAYS-1:0] hit
);

    tag_t            tag_mem [WAYS][SETS];
    logic [SETS-1:0] valid   [WAYS];
    tag_t            tag_q   [WAYS];
    logic [WAYS-1:0] valid_q;

    // tag storage and registered read
    always_ff @(posedge clk) begin
        for (int w = 0; w < WAYS; w++) begin
            if (tag_we[w]) begin
                tag_mem[w][wr_index] <= wr_tag;
            end
            tag_q[w] <= tag_mem[w][rd_index];
        end
    end

    // valid bits, invalidate clears the whole set
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int w = 0; w < WAYS; w++) begin
                valid[w] <= '0;
            end
            valid_q <= '0;
        end else begin
            for (int w = 0; w < WAYS; w++) begin
                if (tag_inval) begin
                    valid[w][wr_index] <= 1'b0;
                end else if (tag_we[w]) begin
                    valid[w][wr_index] <= 1'b1;
                end
                valid_q[w] <= valid[w][rd_index];
            end
        end
    end

    // compare against the buffered request tag
    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            hit[w] = valid_q[w] && (tag_q[w] == cmp_tag);
        end
    end

endmodule

/* dv/dcache_sva.sv */
// protocol assertions for the data cache memory and response ports, with bind
`timescale 1ns/1ps

module dcache_sva
    import dcache_pkg::*;
(
    input logic     clk,
    input logic     rst_n,
    input logic     resp_valid,
    input mem_req_t mem_req,
    input logic     mem_addr_ok,
    input logic     mem_bvalid
);

    int unsigned sva_errors = 0;
    logic        wr_open;

    // write accepted by memory and still waiting for bvalid
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_open <= 1'b0;
        end else if (mem_req.req && mem_req.wr && mem_addr_ok) begin
            wr_open <= 1'b1;
        end else if (mem_bvalid) begin
            wr_open <= 1'b0;
        end
    end

    a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req.req && !mem_addr_ok |=> mem_req.req && $stable(mem_req))
    else begin
        sva_errors++;
        $error("memory request dropped or changed before addr_ok");
    end

    a_no_resp_in_reset: assert property (@(posedge clk) !rst_n |-> !resp_valid)
    else begin
        sva_errors++;
        $error("resp_valid high during reset");
    end

    a_bvalid_after_write: assert property (@(posedge clk) disable iff (!rst_n)
        mem_bvalid |-> wr_open)
    else begin
        sva_errors++;
        $error("bvalid without an open memory write");
    end

    // only one memory transaction at a time, nothing new until bvalid
    a_no_req_while_write_open: assert property (@(posedge clk) disable iff (!rst_n)
        wr_open |-> !mem_req.req)
    else begin
        sva_errors++;
        $error("new memory request before bvalid of the previous write");
    end

endmodule

bind dcache_top dcache_sva i_sva (
    .clk         (clk),
    .rst_n       (rst_n),
    .resp_valid  (resp_valid),
    .mem_req     (mem_req),
    .mem_addr_ok (mem_addr_ok),
    .mem_bvalid  (mem_bvalid)
);

/* dv/mem_model.sv */
// memory responder for the data cache with random handshake latency
`timescale 1ns/1ps

module mem_model
    import dcache_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  mem_req_t mem_req,
    output logic     mem_addr_ok,
    output logic     mem_data_ok,
    output logic     mem_bvalid,
    output line_t    mem_rline
);

    // only written words are stored, the rest follow the fill pattern
    word_t    mem [addr_t];
    mem_req_t cur;

    function automatic word_t fill_word(addr_t a);
        return (a * 32'h9e37_79b9) ^ 32'h3c6e_f372;
    endfunction

    function automatic word_t read_word(addr_t a);
        return mem.exists(a) ? mem[a] : fill_word(a);
    endfunction

    initial begin
        int unsigned lat;
        word_t       w;

        mem_addr_ok = 1'b0;
        mem_data_ok = 1'b0;
        mem_bvalid  = 1'b0;
        mem_rline   = '0;
        forever begin
            @(posedge clk);
            #1;
            if (rst_n && mem_req.req) begin
                // address phase, 1 to 5 cycles counting the request cycle
                lat = $urandom_range(1, 5);
                repeat (lat - 1) begin
                    @(posedge clk);
                    #1;
                end
                cur         = mem_req;
                mem_addr_ok = 1'b1;
                @(posedge clk);
                #1;
                mem_addr_ok = 1'b0;
                // data or write response phase
                lat = $urandom_range(1, 5);
                repeat (lat - 1) begin
                    @(posedge clk);
                    #1;
                end
                if (cur.wr) begin
                    w = read_word(cur.addr);
                    for (int b = 0; b < 4; b++) begin
                        if (cur.wstrb[b]) begin
                            w[b*8 +: 8] = cur.wdata[b*8 +: 8];
                        end
                    end
                    mem[cur.addr] = w;
                    mem_bvalid    = 1'b1;
                end else begin
                    for (int i = 0; i < LINE_WORDS; i++) begin
                        mem_rline[i*32 +: 32] = read_word(cur.addr + 4 * i);
                    end
                    mem_data_ok = 1'b1;
                end
                @(posedge clk);
                #1;
                mem_bvalid  = 1'b0;
                mem_data_ok = 1'b0;
            end
        end
    end

endmodule

/* dv/tb_dcache.sv */
// data cache testbench with clock, reset, directed and random stimulus, shadow memory, checks
`timescale 1ns/1ps

module tb_dcache
    import dcache_pkg::*;
();

    localparam int          TIMEOUT = 200;
    localparam logic [31:0] SEED    = 32'h47da_4c7a;

    logic       clk;
    logic       rst_n;
    logic       req_valid;
    cache_req_t req;
    logic       req_ready;
    logic       resp_valid;
    word_t      resp_data;
    mem_req_t   mem_req;
    logic       mem_addr_ok;
    logic       mem_data_ok;
    logic       mem_bvalid;
    line_t      mem_rline;

    word_t       shadow [addr_t];
    word_t       exp_q [$];
    mem_req_t    wr_q [$];
    addr_t       last_addr;
    int unsigned mismatches     = 0;
    int unsigned timeouts       = 0;
    int unsigned other_errors   = 0;
    int unsigned reads_accepted = 0;
    int unsigned resp_count     = 0;
    int unsigned mem_reads      = 0;
    int unsigned mem_writes     = 0;

    dcache_top i_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_valid   (req_valid),
        .req         (req),
        .req_ready   (req_ready),
        .resp_valid  (resp_valid),
        .resp_data   (resp_data),
        .mem_req     (mem_req),
        .mem_addr_ok (mem_addr_ok),
        .mem_data_ok (mem_data_ok),
        .mem_bvalid  (mem_bvalid),
        .mem_rline   (mem_rline)
    );

    mem_model i_mem (
        .clk         (clk),
        .rst_n       (rst_n),
        .mem_req     (mem_req),
        .mem_addr_ok (mem_addr_ok),
        .mem_data_ok (mem_data_ok),
        .mem_bvalid  (mem_bvalid),
        .mem_rline   (mem_rline)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // reference memory and check helpers
    ////////////////////////////////////////////////////////////////////////////

    // untouched memory holds a pattern of the word address
    function automatic word_t initial_word(addr_t a);
        return (a * 32'h9e37_79b9) ^ 32'h3c6e_f372;
    endfunction

    function automatic word_t shadow_word(addr_t a);
        return shadow.exists(a) ? shadow[a] : initial_word(a);
    endfunction

    function automatic addr_t make_addr(tag_t tag, index_t idx, offset_t off);
        return {tag, idx, off, 2'b00};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            mismatches++;
            $display("Mismatch at %0t ns: %s expected %h, got %h", $time, name, exp, got);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond) else begin
            other_errors++;
            $display("Error at %0t ns: %s", $time, what);
        end
    endtask

    task automatic report_timeout(input string what);
        timeouts++;
        $display("Timeout at %0t ns: %s did not happen within %0d cycles", $time, what, TIMEOUT);
    endtask

    // drive one request and return in the cycle after acceptance
    task automatic issue(input logic write, input logic inval, input addr_t addr,
                         input word_t wdata, input wstrb_t wstrb);
        int unsigned n;
        mem_req_t    exp_wr;
        word_t       w;

        req_valid = 1'b1;
        req.addr  = addr;
        req.wdata = wdata;
        req.wstrb = wstrb;
        req.write = write;
        req.inval = inval;
        n = 0;
        @(negedge clk);
        while (!req_ready && n < TIMEOUT) begin
            n++;
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        if (n >= TIMEOUT) begin
            report_timeout("request acceptance");
            return;
        end
        last_addr = addr;
        if (write && !inval) begin
            exp_wr       = '0;
            exp_wr.addr  = addr;
            exp_wr.wdata = wdata;
            exp_wr.wstrb = wstrb;
            wr_q.push_back(exp_wr);
            w = shadow_word(addr);
            for (int b = 0; b < 4; b++) begin
                if (wstrb[b]) begin
                    w[b*8 +: 8] = wdata[b*8 +: 8];
                end
            end
            shadow[addr] = w;
        end else if (!inval) begin
            reads_accepted++;
            exp_q.push_back(shadow_word(addr));
        end
    endtask

    // wait until every response and memory write has come back
    task automatic drain();
        int unsigned n;

        n = 0;
        @(negedge clk);
        #1;
        while (!(req_ready && exp_q.size() == 0 && wr_q.size() == 0) && n < TIMEOUT) begin
            n++;
            @(negedge clk);
            #1;
        end
        if (n >= TIMEOUT) begin
            report_timeout("completion of outstanding requests");
        end
        @(posedge clk);
        #1;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // response and memory bus monitor
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        mem_req_t exp_wr;

        if (rst_n) begin
            if (resp_valid) begin
                resp_count++;
                check_true(exp_q.size() != 0, "response with no read outstanding");
                if (exp_q.size() != 0) begin
                    check_value("resp_data", resp_data, exp_q.pop_front());
                end
            end
            // every transfer on the memory bus is a word transfer
            if (mem_req.req && mem_addr_ok) begin
                check_value("mem_req.size", mem_req.size, 32'd2);
            end
            if (mem_req.req && mem_addr_ok && mem_req.wr) begin
                mem_writes++;
                check_true(wr_q.size() != 0, "memory write with no store outstanding");
                if (wr_q.size() != 0) begin
                    exp_wr = wr_q.pop_front();
                    check_value("mem_req.addr", mem_req.addr, exp_wr.addr);
                    check_value("mem_req.wdata", mem_req.wdata, exp_wr.wdata);
                    check_value("mem_req.wstrb", mem_req.wstrb, exp_wr.wstrb);
                end
            end else if (mem_req.req && mem_addr_ok) begin
                mem_reads++;
                check_value("mem_req.addr", mem_req.addr, {last_addr[31:4], 4'h0});
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        addr_t       a;
        addr_t       b;
        addr_t       c;
        int unsigned rd0;
        int unsigned wr0;
        int unsigned total;

        void'($urandom(SEED));
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        last_addr = '0;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // idle state after reset
        repeat (3) begin
            @(negedge clk);
            check_value("req_ready", req_ready, 1);
            check_value("mem_req.req", mem_req.req, 0);
            check_value("resp_valid", resp_valid, 0);
        end
        @(posedge clk);
        #1;

        // read miss, then a hit on the same line
        rd0 = mem_reads;
        issue(1'b0, 1'b0, make_addr(24'h0123, 4'd1, 2'd2), '0, '0);
        drain();
        check_value("memory read count", mem_reads - rd0, 1);
        rd0 = mem_reads;
        issue(1'b0, 1'b0, make_addr(24'h0123, 4'd1, 2'd3), '0, '0);
        @(negedge clk);
        check_value("resp_valid", resp_valid, 1);
        drain();
        check_value("memory read count", mem_reads - rd0, 0);

        // strobed write hit merges, write miss does not allocate
        a = make_addr(24'h0456, 4'd2, 2'd1);
        issue(1'b0, 1'b0, a, '0, '0);
        drain();
        wr0 = mem_writes;
        issue(1'b1, 1'b0, a, 32'h1122_3344, 4'b0101);
        drain();
        check_value("memory write count", mem_writes - wr0, 1);
        rd0 = mem_reads;
        issue(1'b0, 1'b0, a, '0, '0);
        drain();
        check_value("memory read count", mem_reads - rd0, 0);
        b = make_addr(24'h0789, 4'd3, 2'd0);
        issue(1'b1, 1'b0, b, 32'hc0de_5a17, 4'b1010);
        drain();
        rd0 = mem_reads;
        issue(1'b0, 1'b0, b, '0, '0);
        drain();
        check_value("memory read count", mem_reads - rd0, 1);

        // lru in set 5 with lines A, B, C
        a = make_addr(24'h0a00, 4'd5, 2'd0);
        b = make_addr(24'h0b00, 4'd5, 2'd1);
        c = make_addr(24'h0c00, 4'd5, 2'd2);
        issue(1'b0, 1'b0, a, '0, '0);
        drain();
        issue(1'b0, 1'b0, b, '0, '0);
        drain();
        issue(1'b0, 1'b0, a, '0, '0);
        drain();
        issue(1'b0, 1'b0, c, '0, '0);
        drain();
        rd0 = mem_reads;
        issue(1'b0, 1'b0, a, '0, '0);
        drain();
        check_value("memory read count", mem_reads - rd0, 0);
        rd0 = mem_reads;
        issue(1'b0, 1'b0, b, '0, '0);
        drain();
        check_value("memory read count", mem_reads - rd0, 1);

        // invalidate set 5, both lines refetched
        issue(1'b0, 1'b1, make_addr('0, 4'd5, 2'd0), '0, '0);
        drain();
        rd0 = mem_reads;
        issue(1'b0, 1'b0, a, '0, '0);
        issue(1'b0, 1'b0, b, '0, '0);
        drain();
        check_value("memory read count", mem_reads - rd0, 2);

        // random mix over sets 8 to 15, back to back
        for (int i = 0; i < 300; i++) begin
            a = make_addr(tag_t'(24'h0d00 + $urandom_range(0, 2)),
                          index_t'(4'd8 + $urandom_range(0, 7)),
                          offset_t'($urandom_range(0, 3)));
            if ($urandom_range(0, 1)) begin
                issue(1'b1, 1'b0, a, $urandom, wstrb_t'($urandom_range(1, 15)));
            end else begin
                issue(1'b0, 1'b0, a, '0, '0);
            end
        end
        drain();
        check_value("response count", resp_count, reads_accepted);

        total = mismatches + timeouts + other_errors + i_dut.i_sva.sva_errors;
        $display("errors: %0d mismatches, %0d timeouts, %0d other, %0d assertion failures",
                 mismatches, timeouts, other_errors, i_dut.i_sva.sva_errors);
        if (total == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* hdl/dcache_top.sv */
// data cache top level, controller with tag, data and LRU arrays
`timescale 1ns/1ps

module dcache_top
    import dcache_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    // pipeline
    input  logic       req_valid,
    input  cache_req_t req,
    output logic       req_ready,
    output logic       resp_valid,
    output word_t      resp_data,
    // memory
    output mem_req_t   mem_req,
    input  logic       mem_addr_ok,
    input  logic       mem_data_ok,
    input  logic       mem_bvalid,
    input  line_t      mem_rline
);

    logic [WAYS-1:0]  hit;
    line_t [WAYS-1:0] rd_lines;
    logic             victim_way;
    index_t           rd_index;
    index_t           wr_index;
    tag_t             wr_tag;
    logic [WAYS-1:0]  tag_we;
    logic             tag_inval;
    logic [WAYS-1:0]  word_we;
    offset_t          wr_offset;
    wstrb_t           wr_strb;
    word_t            wr_word;
    logic [WAYS-1:0]  fill_we;
    logic             lru_use;
    logic             lru_use_way;

    dcache_ctrl i_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_valid   (req_valid),
        .req         (req),
        .req_ready   (req_ready),
        .resp_valid  (resp_valid),
        .resp_data   (resp_data),
        .hit         (hit),
        .rd_lines    (rd_lines),
        .victim_way  (victim_way),
        .mem_req     (mem_req),
        .mem_addr_ok (mem_addr_ok),
        .mem_data_ok (mem_data_ok),
        .mem_bvalid  (mem_bvalid),
        .mem_rline   (mem_rline),
        .rd_index    (rd_index),
        .wr_index    (wr_index),
        .wr_tag      (wr_tag),
        .tag_we      (tag_we),
        .tag_inval   (tag_inval),
        .word_we     (word_we),
        .wr_offset   (wr_offset),
        .wr_strb     (wr_strb),
        .wr_word     (wr_word),
        .fill_we     (fill_we),
        .lru_use     (lru_use),
        .lru_use_way (lru_use_way)
    );

    // compare tag is the buffered request tag, same as the write tag
    dcache_tagv i_tagv (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_index  (rd_index),
        .cmp_tag   (wr_tag),
        .wr_index  (wr_index),
        .wr_tag    (wr_tag),
        .tag_we    (tag_we),
        .tag_inval (tag_inval),
        .hit       (hit)
    );

    dcache_data i_data (
        .clk       (clk),
        .rd_index  (rd_index),
        .wr_index  (wr_index),
        .wr_offset (wr_offset),
        .wr_strb   (wr_strb),
        .wr_word   (wr_word),
        .word_we   (word_we),
        .fill_we   (fill_we),
        .fill_line (mem_rline),
        .rd_lines  (rd_lines)
    );

    dcache_lru i_lru (
        .clk        (clk),
        .rst_n      (rst_n),
        .index      (wr_index),
        .use_en     (lru_use),
        .use_way    (lru_use_way),
        .victim_way (victim_way)
    );

endmodule
